// File: hw/cpu_isa_pkg.sv
// instruction set: opcodes, alu operations, branch conditions, instruction word formats, flags
package cpu_isa_pkg;

	// top nibble of every instruction word
	typedef enum logic [3:0] {
		OP_NOP    = 4'h0,
		OP_IMM    = 4'h1,	// 12-bit prefix for the next instruction
		OP_ALU_RR = 4'h2,
		OP_ALU_RI = 4'h3,
		OP_BRANCH = 4'h4,
		OP_STORE  = 4'h5	// 6..f decode as nop
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_PASS_B = 4'h0,
		ALU_ADD    = 4'h1,
		ALU_SUB    = 4'h2,
		ALU_AND    = 4'h3,
		ALU_OR     = 4'h4,
		ALU_XOR    = 4'h5,
		ALU_SHL    = 4'h6,	// a << 1
		ALU_SHR    = 4'h7	// a >> 1, codes 8..f pass b
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_Z, BR_NZ, BR_S, BR_NS, BR_C, BR_NC, BR_A, BR_L
	} br_cond_e;

	// alu register-register: rd is also the a operand
	typedef struct packed {
		opcode_e    op;
		alu_op_e    alu;
		logic       rsvd7;
		logic [2:0] rd;
		logic       rsvd3;
		logic [2:0] rb;
	} rr_fmt_t;

	typedef struct packed {
		opcode_e    op;
		alu_op_e    alu;
		logic       rsvd7;
		logic [2:0] rd;
		logic [3:0] k;		// low nibble of constant
	} ri_fmt_t;

	typedef struct packed {
		opcode_e    op;
		logic       rsvd11;
		br_cond_e   cond;
		logic [3:0] rsvd7_4;
		logic [3:0] tgt_lo;	// target = {prefix, tgt_lo}
	} br_fmt_t;

	typedef struct packed {
		opcode_e     op;
		logic [11:0] prefix;
	} imm_fmt_t;

	typedef struct packed {
		opcode_e    op;
		logic [4:0] rsvd11_7;
		logic [2:0] ra;		// address register
		logic       rsvd3;
		logic [2:0] rd;		// data register
	} st_fmt_t;

	// one word, read through whichever format the opcode selects
	typedef union packed {
		rr_fmt_t  rr_fmt;
		ri_fmt_t  ri_fmt;
		br_fmt_t  br_fmt;
		imm_fmt_t imm_fmt;
		st_fmt_t  st_fmt;
	} instr_u;

	localparam logic [15:0] NOP_WORD = 16'h0000;

	typedef struct packed {
		logic c;	// carry out of add, borrow of sub
		logic z;
		logic s;
	} flags_t;

endpackage

// File: hw/cpu_ctrl_pkg.sv
// control bundles from the pipeline controller to register file, alu and memory bus
package cpu_ctrl_pkg;

	import cpu_isa_pkg::*;

	// register file controls, all vectors active low
	typedef struct packed {
		logic [7:0] ld_alu_b;	// load rN from alu result
		logic [7:0] inc_b;	// increment rN
		logic [2:0] a_sel;	// register on alu a
		logic [2:0] b_sel;	// register on alu b
		logic [2:0] m_sel;	// register on memory write data
		logic [2:0] addr_sel;	// register on memory address
	} rf_ctrl_t;

	typedef struct packed {
		alu_op_e op;
		logic    b_from_const_b;	// 0 selects the constant for b
		logic    flags_we;		// capture c/z/s at end of cycle
	} alu_ctrl_t;

	// memory bus strobes, active low
	typedef struct packed {
		logic oe_b;	// fetch
		logic wr_b;	// store
	} mem_ctrl_t;

	// idle values
	localparam rf_ctrl_t RF_CTRL_IDLE = '{
		ld_alu_b: 8'hff,
		inc_b:    8'hff,
		a_sel:    3'd0,
		b_sel:    3'd0,
		m_sel:    3'd0,
		addr_sel: 3'd7	// pc on the address bus
	};

	localparam alu_ctrl_t ALU_CTRL_IDLE = '{
		op:             ALU_PASS_B,
		b_from_const_b: 1'b1,
		flags_we:       1'b0
	};

endpackage

// File: hw/pipeline_ctrl.sv
// pipeline controller with fetch stage register, stall bit, immediate prefix, decode and branch resolution
`timescale 1ns/1ps

module pipeline_ctrl
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;
(
	input  logic        CLK,
	input  logic        RSTb,
	input  logic [15:0] mem_rdata,	// fetched word valid in the same cycle
	input  flags_t      flags,
	output rf_ctrl_t    rf_ctrl,
	output alu_ctrl_t   alu_ctrl,
	output mem_ctrl_t   mem_ctrl,
	output logic [15:0] const_val	// {prefix, low nibble} to alu b mux
);

	instr_u      stage_q;	// word in execute
	instr_u      stage_d;
	logic        stall_q;	// no fetch this cycle
	logic        stall_d;
	logic [11:0] prefix_q;	// from the previous imm, else zero
	logic [11:0] prefix_d;
	logic        br_taken;

	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			stage_q  <= NOP_WORD;
			stall_q  <= 1'b0;	// first fetch in the cycle after release
			prefix_q <= '0;
		end
		else
		begin
			stage_q  <= stage_d;
			stall_q  <= stall_d;
			prefix_q <= prefix_d;
		end
	end

	function automatic logic cond_met(input br_cond_e cond, input flags_t f);
		case (cond)
			BR_Z:    cond_met = f.z;
			BR_NZ:   cond_met = !f.z;
			BR_S:    cond_met = f.s;
			BR_NS:   cond_met = !f.s;
			BR_C:    cond_met = f.c;
			BR_NC:   cond_met = !f.c;
			default: cond_met = 1'b1;	// ba and bl without link
		endcase
	endfunction

	assign br_taken = (stage_q.br_fmt.op == OP_BRANCH) && cond_met(stage_q.br_fmt.cond, flags);

	always_comb
	begin
		rf_ctrl   = RF_CTRL_IDLE;
		alu_ctrl  = ALU_CTRL_IDLE;
		mem_ctrl  = '{oe_b: 1'b1, wr_b: 1'b1};
		const_val = {prefix_q, 4'h0};
		stage_d   = NOP_WORD;
		stall_d   = 1'b0;
		prefix_d  = '0;	// prefix lives for one instruction only

		// fetch at r7 and step the pc, strobes stay high in reset
		if (!stall_q && RSTb)
		begin
			mem_ctrl.oe_b    = 1'b0;
			rf_ctrl.inc_b[7] = 1'b0;
			stage_d          = mem_rdata;
		end

		case (stage_q.rr_fmt.op)
			OP_IMM:
			begin
				prefix_d = stage_q.imm_fmt.prefix;
			end
			OP_ALU_RR:
			begin
				alu_ctrl.op                          = stage_q.rr_fmt.alu;
				alu_ctrl.flags_we                    = 1'b1;
				rf_ctrl.a_sel                        = stage_q.rr_fmt.rd;
				rf_ctrl.b_sel                        = stage_q.rr_fmt.rb;
				rf_ctrl.ld_alu_b[stage_q.rr_fmt.rd] = 1'b0;	// write back to rd
			end
			OP_ALU_RI:
			begin
				alu_ctrl.op                          = stage_q.ri_fmt.alu;
				alu_ctrl.flags_we                    = 1'b1;
				alu_ctrl.b_from_const_b              = 1'b0;	// b = constant
				const_val[3:0]                       = stage_q.ri_fmt.k;
				rf_ctrl.a_sel                        = stage_q.ri_fmt.rd;
				rf_ctrl.ld_alu_b[stage_q.ri_fmt.rd] = 1'b0;
			end
			OP_BRANCH:
			begin
				if (br_taken)
				begin
					alu_ctrl.op             = ALU_PASS_B;	// r7 <= constant
					alu_ctrl.b_from_const_b = 1'b0;
					const_val[3:0]          = stage_q.br_fmt.tgt_lo;
					rf_ctrl.ld_alu_b[7]     = 1'b0;
					stage_d                 = NOP_WORD;	// drop the shadow word
					stall_d                 = 1'b1;	// target fetched one cycle later
				end
			end
			OP_STORE:
			begin
				mem_ctrl.oe_b    = 1'b1;	// bus belongs to the write
				mem_ctrl.wr_b    = 1'b0;
				rf_ctrl.inc_b[7] = 1'b1;	// skipped word is fetched next cycle
				rf_ctrl.addr_sel = stage_q.st_fmt.ra;
				rf_ctrl.m_sel    = stage_q.st_fmt.rd;
				stage_d          = NOP_WORD;
			end
			default: ;	// nop and unused opcodes
		endcase

		// an alu write to r7 overrides the pc step
		rf_ctrl.inc_b = rf_ctrl.inc_b | ~rf_ctrl.ld_alu_b;
	end

	// fetch and store never share the bus
	a_strobes_excl: assert property (@(posedge CLK) disable iff (!RSTb)
		mem_ctrl.oe_b || mem_ctrl.wr_b)
		else $error("fetch and write strobes low in the same cycle");

	// the cycle after a taken branch is a bubble
	a_branch_bubble: assert property (@(posedge CLK) disable iff (!RSTb)
		br_taken |=> mem_ctrl.oe_b)
		else $error("fetch in the cycle after a taken branch");

endmodule

// File: hw/register_file.sv
// register file: eight 16-bit registers, r7 is the pc, active-low load/increment, four read ports
`timescale 1ns/1ps

module register_file
	import cpu_ctrl_pkg::*;
#(
	parameter logic [15:0] RESET_PC = 16'h0000
)
(
	input  logic        CLK,
	input  logic        RSTb,
	input  rf_ctrl_t    rf_ctrl,
	input  logic [15:0] alu_y,	// write-back value
	output logic [15:0] a_data,
	output logic [15:0] b_data,
	output logic [15:0] m_data,	// store data
	output logic [15:0] addr	// memory address
);

	logic [15:0] regs [8];

	for (genvar i = 0; i < 8; i++)
	begin : g_reg
		if (i == 7)
		begin : g_pc
			// pc is the only register with a reset value
			always_ff @(posedge CLK)
			begin
				if (!RSTb)
					regs[i] <= RESET_PC;
				else if (!rf_ctrl.ld_alu_b[i])
					regs[i] <= alu_y;	// branch target or alu write
				else if (!rf_ctrl.inc_b[i])
					regs[i] <= regs[i] + 16'd1;	// step past fetched word
			end
		end
		else
		begin : g_gpr
			always_ff @(posedge CLK)
			begin
				if (!rf_ctrl.ld_alu_b[i])
					regs[i] <= alu_y;
				else if (!rf_ctrl.inc_b[i])
					regs[i] <= regs[i] + 16'd1;
			end
		end
	end

	// read ports, combinational
	assign a_data = regs[rf_ctrl.a_sel];
	assign b_data = regs[rf_ctrl.b_sel];
	assign m_data = regs[rf_ctrl.m_sel];
	assign addr   = regs[rf_ctrl.addr_sel];

	// controller resolves load against increment before it gets here
	a_ld_inc_excl: assert property (@(posedge CLK) disable iff (!RSTb)
		(rf_ctrl.ld_alu_b | rf_ctrl.inc_b) == 8'hff)
		else $error("register loaded and incremented in the same cycle");

endmodule

// File: hw/alu_flags.sv
// 16-bit alu with b operand select and registered carry/zero/sign flags
`timescale 1ns/1ps

module alu_flags
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;
(
	input  logic        CLK,
	input  logic        RSTb,
	input  alu_ctrl_t   alu_ctrl,
	input  logic [15:0] a_data,
	input  logic [15:0] b_data,	// from register file
	input  logic [15:0] const_val,	// from controller
	output logic [15:0] alu_y,
	output flags_t      flags
);

	logic [15:0] b_op;
	logic        carry;	// carry out or borrow, zero for other ops

	// b mux, constant when strobe low
	assign b_op = alu_ctrl.b_from_const_b ? b_data : const_val;

	always_comb
	begin
		carry = 1'b0;
		case (alu_ctrl.op)
			ALU_ADD:
			begin
				{carry, alu_y} = {1'b0, a_data} + {1'b0, b_op};
			end
			ALU_SUB:
			begin
				{carry, alu_y} = {1'b0, a_data} - {1'b0, b_op};	// bit 16 is borrow
			end
			ALU_AND:
			begin
				alu_y = a_data & b_op;
			end
			ALU_OR:
			begin
				alu_y = a_data | b_op;
			end
			ALU_XOR:
			begin
				alu_y = a_data ^ b_op;
			end
			ALU_SHL:
			begin
				alu_y = {a_data[14:0], 1'b0};
			end
			ALU_SHR:
			begin
				alu_y = {1'b0, a_data[15:1]};
			end
			default:
			begin
				alu_y = b_op;	// pass b, also codes 8..f
			end
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!RSTb)
			flags <= '0;
		else if (alu_ctrl.flags_we)
		begin
			flags.c <= carry;
			flags.z <= (alu_y == 16'h0000);
			flags.s <= alu_y[15];
		end
	end

endmodule

// File: hw/cpu16_core.sv
// cpu top: pipeline controller, register file and alu on one shared memory bus
`timescale 1ns/1ps

module cpu16_core
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;
#(
	parameter logic [15:0] RESET_PC = 16'h0000
)
(
	input  logic        CLK,
	input  logic        RSTb,
	input  logic [15:0] mem_rdata,	// combinational read data
	output logic [15:0] mem_addr,
	output logic [15:0] mem_wdata,
	output logic        mem_oe_b,	// fetch strobe
	output logic        mem_wr_b	// write strobe
);

	rf_ctrl_t    rf_ctrl;
	alu_ctrl_t   alu_ctrl;
	mem_ctrl_t   mem_ctrl;
	flags_t      flags;
	logic [15:0] const_val;
	logic [15:0] a_data;
	logic [15:0] b_data;
	logic [15:0] alu_y;

	pipeline_ctrl u_ctrl (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.mem_rdata (mem_rdata),
		.flags     (flags),
		.rf_ctrl   (rf_ctrl),
		.alu_ctrl  (alu_ctrl),
		.mem_ctrl  (mem_ctrl),
		.const_val (const_val)
	);

	register_file #(
		.RESET_PC (RESET_PC)
	) u_rf (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.rf_ctrl (rf_ctrl),
		.alu_y   (alu_y),
		.a_data  (a_data),
		.b_data  (b_data),
		.m_data  (mem_wdata),	// store data straight to the bus
		.addr    (mem_addr)	// pc or store address
	);

	alu_flags u_alu (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.alu_ctrl  (alu_ctrl),
		.a_data    (a_data),
		.b_data    (b_data),
		.const_val (const_val),
		.alu_y     (alu_y),
		.flags     (flags)
	);

	assign mem_oe_b = mem_ctrl.oe_b;
	assign mem_wr_b = mem_ctrl.wr_b;

endmodule

// File: verification/clock_gen.sv
// testbench clock and reset generator
`timescale 1ns/1ps

module clock_gen
(
	output logic CLK,
	output logic RSTb
);

	initial
	begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;	// 20 ns period
	end

	initial
	begin
		RSTb = 1'b0;
		repeat (4) @(posedge CLK);	// four reset cycles
		@(negedge CLK);
		RSTb = 1'b1;	// released on the falling edge
	end

endmodule

// File: verification/cpu16_tb.sv
// cpu16_core testbench with memory model, expected-store table, bus assertions, watchdog, result
`timescale 1ns/1ps

module cpu16_tb;

	localparam int N_ST = 11;	// checked stores before the final one
	localparam int WATCHDOG_CYCLES = 400;
	localparam int CLK_PERIOD = 20;
	localparam logic [15:0] N_TAKEN = 16'd10;	// taken branches in the program
	localparam logic [1:0] K_FETCH = 2'd0;
	localparam logic [1:0] K_WRITE = 2'd1;
	localparam logic [1:0] K_IDLE = 2'd2;

	// r0 = 1234, r1 = f0f0, r2 = r0 op r1 (pass_b takes r1)
	localparam logic [15:0] EXP_ADDR [N_ST] = '{
		16'h0080, 16'h0081, 16'h0082, 16'h0083, 16'h0084, 16'h0085,
		16'h0086, 16'h0087, 16'h0088, 16'h0089, 16'h008a
	};
	localparam logic [15:0] EXP_DATA [N_ST] = '{
		16'hf0f0,	// pass_b r1
		16'h0324,	// 1234 + f0f0 with the carry dropped
		16'h2144,	// 1234 - f0f0 with the borrow dropped
		16'h1030,
		16'hf2f4,
		16'he2c4,
		16'h2468,	// 1234 << 1
		16'h091a,	// 1234 >> 1
		16'h0005,	// constant without prefix
		16'habce,	// abc7 + 7 with no prefix left
		16'h0001	// r3 after the branch tests
	};
	string store_name [N_ST] = '{
		"pass_b", "add", "sub", "and", "or", "xor", "shl", "shr",
		"imm_plain", "imm_prefix", "branch_end"
	};

	logic        CLK;
	logic        RSTb;
	logic [15:0] mem_rdata;
	logic [15:0] mem_addr;
	logic [15:0] mem_wdata;
	logic        mem_oe_b;
	logic        mem_wr_b;

	logic [15:0] mem [256];	// shared instruction/data memory
	int          errors = 0;
	int          cyc = 0;
	int          st_idx = 0;	// next table entry
	logic        done = 1'b0;	// final store seen
	logic        have_fetch = 1'b0;
	logic [1:0]  prev_kind = K_IDLE;	// bus use in the previous cycle
	logic [15:0] last_fetch = '0;
	logic [15:0] bubbles = '0;	// cycles without fetch after the first fetch
	logic [15:0] w1 = '0;	// last fetched word
	logic [15:0] w2 = '0;
	logic [15:0] w3 = '0;
	logic [15:0] br_target;
	logic        fetch;
	logic        write;
	logic        idle;

	clock_gen u_clk (
		.CLK  (CLK),
		.RSTb (RSTb)
	);

	cpu16_core dut (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.mem_rdata (mem_rdata),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_oe_b  (mem_oe_b),
		.mem_wr_b  (mem_wr_b)
	);

	initial
	begin
		$readmemh("verification/program.hex", mem);
	end

	assign mem_rdata = mem[mem_addr[7:0]];	// combinational read

	assign fetch = RSTb && !mem_oe_b;
	assign write = RSTb && !mem_wr_b;
	assign idle  = RSTb && mem_oe_b && mem_wr_b && have_fetch;
	// once the bubble is over w2 holds the branch and w3 a possible imm prefix
	assign br_target = {(w3[15:12] == 4'h1) ? w3[11:0] : 12'h000, w2[3:0]};

	task automatic report_mismatch(input string name, input logic [15:0] exp_v,
		input logic [15:0] act_v);
		errors++;
		$display("ERR %s: expected %h, actual %h", name, exp_v, act_v);
	endtask

	task automatic log_failure(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	// bus history and memory writes
	always @(posedge CLK)
	begin
		cyc <= cyc + 1;
		if (RSTb)
		begin
			if (fetch)
			begin
				have_fetch <= 1'b1;
				last_fetch <= mem_addr;
				w1         <= mem_rdata;
				w2         <= w1;
				w3         <= w2;
				prev_kind  <= K_FETCH;
			end
			else if (write)
			begin
				prev_kind            <= K_WRITE;
				mem[mem_addr[7:0]]   <= mem_wdata;
				if (mem_addr == 16'h00ff)
					done <= 1'b1;	// end of program
				else
					st_idx <= st_idx + 1;
			end
			else
				prev_kind <= K_IDLE;
		end
		if (idle)
			bubbles <= bubbles + 16'd1;
	end

	a_reset_strobes: assert property (@(posedge CLK)
		(!RSTb && cyc > 0) |-> (mem_oe_b && mem_wr_b))
		else log_failure("bus strobe active during reset");

	a_fetch_after_reset: assert property (@(posedge CLK)
		$rose(RSTb) |-> fetch)
		else log_failure("no fetch in the first cycle after reset");

	a_first_fetch: assert property (@(posedge CLK) disable iff (!RSTb)
		(fetch && !have_fetch) |-> (mem_addr == 16'h0000))
		else report_mismatch("first_fetch", 16'h0000, $sampled(mem_addr));

	// next word after straight line code, a not-taken branch or a store
	a_fetch_step: assert property (@(posedge CLK) disable iff (!RSTb)
		(fetch && have_fetch && prev_kind != K_IDLE) |-> (mem_addr == last_fetch + 16'd1))
		else report_mismatch("fetch_step", $sampled(last_fetch) + 16'd1, $sampled(mem_addr));

	a_fetch_target: assert property (@(posedge CLK) disable iff (!RSTb)
		(fetch && have_fetch && prev_kind == K_IDLE) |-> (mem_addr == br_target))
		else report_mismatch("branch_target", $sampled(br_target), $sampled(mem_addr));

	a_bubble_cause: assert property (@(posedge CLK) disable iff (!RSTb)
		idle |-> (prev_kind == K_FETCH && w2[15:12] == 4'h4))
		else log_failure("cycle without fetch that does not follow a branch");

	a_one_bubble: assert property (@(posedge CLK) disable iff (!RSTb)
		idle |=> fetch)
		else log_failure("more than one cycle without fetch after a branch");

	a_write_no_fetch: assert property (@(posedge CLK) disable iff (!RSTb)
		write |-> mem_oe_b)
		else log_failure("fetch strobe active during a write");

	a_store_known: assert property (@(posedge CLK) disable iff (!RSTb)
		(write && mem_addr != 16'h00ff) |-> (st_idx < N_ST))
		else log_failure($sformatf("write to %h that is not in the store table",
			$sampled(mem_addr)));

	a_store_addr: assert property (@(posedge CLK) disable iff (!RSTb)
		(write && mem_addr != 16'h00ff && st_idx < N_ST) |-> (mem_addr == EXP_ADDR[st_idx]))
		else report_mismatch(store_name[$sampled(st_idx)], EXP_ADDR[$sampled(st_idx)],
			$sampled(mem_addr));

	a_store_data: assert property (@(posedge CLK) disable iff (!RSTb)
		(write && mem_addr != 16'h00ff && st_idx < N_ST) |-> (mem_wdata == EXP_DATA[st_idx]))
		else report_mismatch(store_name[$sampled(st_idx)], EXP_DATA[$sampled(st_idx)],
			$sampled(mem_wdata));

	// end of run on the store to ff
	initial
	begin
		wait (done);
		@(negedge CLK);
		a_table_done: assert (st_idx == N_ST)
			else log_failure($sformatf("only %0d of %0d expected stores seen",
				st_idx, N_ST));
		// every taken branch leaves exactly one bubble
		a_bubble_count: assert (bubbles == N_TAKEN)
			else report_mismatch("taken_branches", N_TAKEN, bubbles);
		$display("errors: %0d, stores checked: %0d of %0d", errors, st_idx, N_ST);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// about three times the program length
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: program never reached its final store, errors: %0d", errors);
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: verification/program.hex
// test program, four instruction words per line
// comment gives the address of the first word and what the line does
1008 3060 1123 3004 // 00 r6=0080, r0=1234
1F0F 3010 2021 5062 // 04 r1=f0f0, pass_b r2=r1, store
3161 2020 2121 5062 // 08 add
3161 2020 2221 5062 // 0c sub
3161 2020 2321 5062 // 10 and
3161 2020 2421 5062 // 14 or
3161 2020 2521 5062 // 18 xor
3161 2020 2621 5062 // 1c shl
3161 2020 2721 5062 // 20 shr
3161 3025 5062 3161 // 24 constant 5 without prefix
1ABC 3027 3127 5062 // 28 prefix abc, then add 7 without prefix
3161 3030 4100 4200 // 2c r3=0 z set, bnz and bs not taken
4400 1003 4004 5062 // 30 bc not taken, bz to 34
1003 4307 5062 1003 // 34 bns to 37
450A 5062 1003 460D // 38 bnc to 3a, ba to 3d
5062 1004 4700 5062 // 3c bl to 40
3231 4000 4300 4500 // 40 r3=ffff c and s set, bz bns bnc not taken
1004 4107 5062 1004 // 44 bnz to 47
420A 5062 1004 440D // 48 bs to 4a, bc to 4d
5062 3131 4500 1005 // 4c add sets carry, bnc not taken
4402 5062 3131 4400 // 50 bc to 52, add clears carry, bc not taken
1005 4507 5062 5063 // 54 bnc to 57, store r3
100F 305F 5050 0000 // 58 r5=00ff, final store

// File: project.f
hw/cpu_isa_pkg.sv
hw/cpu_ctrl_pkg.sv
hw/pipeline_ctrl.sv
hw/register_file.sv
hw/alu_flags.sv
hw/cpu16_core.sv
verification/clock_gen.sv
verification/cpu16_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Mdir obj_dir
TOP       = cpu16_tb
FILELIST  = project.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir
